/* design/memPkg.sv */
`default_nettype none

package memPkg;

    localparam int AddrWidth = 16;
    localparam int DataWidth = 32;

    typedef logic [AddrWidth-1:0] addrT;

    // number of bytes moved by one access, 1 to 4
    typedef logic [2:0] lenT;

    typedef enum logic [2:0] {
        opLb,
        opLh,
        opLw,
        opLbu,
        opLhu,
        opSb,
        opSh,
        opSw
    } memOpT;

    // one code per port owner, zero when the port is free
    typedef enum logic [1:0] {
        ownerNone = 2'b00,
        ownerData = 2'b01,
        ownerInst = 2'b10
    } ownerT;

    typedef struct packed {
        logic                 en;
        logic                 isStore;
        lenT                  len;
        addrT                 addr;
        logic [DataWidth-1:0] wdata;
    } dataReqT;

    typedef struct packed {
        logic                 en;
        memOpT                op;
        addrT                 addr;
        logic [DataWidth-1:0] wdata;
    } lsuReqT;

    typedef struct packed {
        logic                 valid;
        addrT                 pc;
        logic [DataWidth-1:0] inst;
        addrT                 predPc;
    } fetchRespT;

endpackage

`default_nettype wire

/* design/byteRam.sv */
`default_nettype none
`timescale 1ns/100ps

module byteRam #(
    parameter int AddrWidth = memPkg::AddrWidth
) (
    input  logic                 clk,
    input  logic [AddrWidth-1:0] addr,
    input  logic                 we,
    input  logic [7:0]           wdata,
    output logic [7:0]           rdata
);

    logic [7:0] mem [2**AddrWidth];

    // read data shows up the cycle after the address
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

/* design/memCtrl.sv */
`default_nettype none
`timescale 1ns/100ps

module memCtrl import memPkg::*; #(
    parameter int AddrWidth = memPkg::AddrWidth
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rdy,
    input  logic                 ioBufferFull,

    input  dataReqT              dataReq,
    output logic                 dataDone,
    output logic [DataWidth-1:0] dataRdata,

    input  logic                 instEn,
    input  logic [AddrWidth-1:0] instAddr,
    output logic                 instDone,
    output logic [DataWidth-1:0] instWord,

    output logic [AddrWidth-1:0] ramAddr,
    output logic                 ramWe,
    output logic [7:0]           ramWdata,
    input  logic [7:0]           ramRdata,

    output ownerT                owner
);

    typedef enum logic [1:0] {
        idle,
        readData,
        writeData,
        readInst
    } stateT;

    stateT                state;
    lenT                  stage;
    lenT                  lenReg;
    logic [AddrWidth-1:0] addrReg;
    logic [DataWidth-1:0] shiftReg;

    logic                 stall;
    logic                 lastCycle;
    logic [DataWidth-1:0] shifted;
    logic [5:0]           alignShift;

    assign stall = !rdy || ioBufferFull;

    // loads end one stage after the last byte address, stores on it
    always_comb begin
        case (state)
            readData, readInst: begin
                lastCycle = (stage == lenReg);
            end
            writeData: begin
                lastCycle = (stage == lenT'(lenReg - lenT'(1)));
            end
            default: begin
                lastCycle = 1'b0;
            end
        endcase
    end

    assign dataDone = !stall && lastCycle && (state == readData || state == writeData);
    assign instDone = !stall && lastCycle && (state == readInst);

    // byte k of a read is addressed at stage k and returns at stage k+1.
    // A frozen cycle re-reads the previous byte so ramRdata keeps it.
    assign ramAddr  = addrReg + AddrWidth'(stage) - AddrWidth'(stall);
    assign ramWe    = !stall && (state == writeData);
    assign ramWdata = shiftReg[7:0];

    // newest byte enters at the top, so short loads need a right shift
    assign shifted    = {ramRdata, shiftReg[DataWidth-1:8]};
    assign alignShift = {lenT'(lenT'(4) - lenReg), 3'b000};
    assign dataRdata  = shifted >> alignShift;
    // fetch is always four bytes
    assign instWord   = shifted;

    always_comb begin
        owner = ownerNone;
        if (!stall) begin
            case (state)
                readData, writeData: begin
                    owner = ownerData;
                end
                readInst: begin
                    owner = ownerInst;
                end
                default: begin
                    owner = ownerNone;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            stage <= '0;
        end else if (!stall) begin
            if (state == idle) begin
                stage <= '0;
                // data side wins when both ask at once
                if (dataReq.en) begin
                    if (dataReq.isStore) begin
                        state <= writeData;
                    end else begin
                        state <= readData;
                    end
                end else if (instEn) begin
                    state <= readInst;
                end
            end else if (lastCycle) begin
                state <= idle;
                stage <= '0;
            end else begin
                stage <= stage + lenT'(1);
            end
        end
    end

    // latched on acceptance, then shifted by one byte per stage
    always_ff @(posedge clk) begin
        if (!stall) begin
            if (state == idle) begin
                if (dataReq.en) begin
                    addrReg <= AddrWidth'(dataReq.addr);
                    lenReg  <= dataReq.len;
                end else begin
                    addrReg <= instAddr;
                    lenReg  <= lenT'(4);
                end
                shiftReg <= dataReq.wdata;
            end else begin
                shiftReg <= shifted;
            end
        end
    end

endmodule

`default_nettype wire

/* design/instFetch.sv */
`default_nettype none
`timescale 1ns/100ps

module instFetch import memPkg::*; #(
    parameter int                   AddrWidth = memPkg::AddrWidth,
    parameter logic [AddrWidth-1:0] BootPc    = '0
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 fetchEn,
    input  logic                 redirect,
    input  logic [AddrWidth-1:0] redirectPc,

    output logic                 instEn,
    output logic [AddrWidth-1:0] instAddr,
    input  logic                 instDone,
    input  logic [DataWidth-1:0] instWord,

    output fetchRespT            fetchResp
);

    localparam logic [6:0] OpJal    = 7'b1101111;
    localparam logic [6:0] OpBranch = 7'b1100011;

    logic [AddrWidth-1:0] pc;
    logic [AddrWidth-1:0] predPc;
    logic                 busy;
    logic [DataWidth-1:0] jImm;
    logic [DataWidth-1:0] bImm;

    assign jImm = {{12{instWord[31]}}, instWord[19:12], instWord[20], instWord[30:21], 1'b0};
    assign bImm = {{20{instWord[31]}}, instWord[7], instWord[30:25], instWord[11:8], 1'b0};

    // backward branches taken, forward ones not
    always_comb begin
        predPc = pc + AddrWidth'(4);
        if (instWord[6:0] == OpJal) begin
            predPc = pc + AddrWidth'(jImm);
        end else if (instWord[6:0] == OpBranch && bImm[DataWidth-1]) begin
            predPc = pc + AddrWidth'(bImm);
        end
    end

    // keep the request up until done even if fetchEn drops
    assign instEn   = fetchEn || busy;
    assign instAddr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc   <= BootPc;
            busy <= 1'b0;
        end else begin
            busy <= instEn && !instDone;
            if (instDone) begin
                if (redirect) begin
                    pc <= redirectPc;
                end else begin
                    pc <= predPc;
                end
            end else if (redirect && !instEn) begin
                pc <= redirectPc;
            end
        end
    end

    always_comb begin
        fetchResp.valid  = instDone;
        fetchResp.pc     = addrT'(pc);
        fetchResp.inst   = instWord;
        fetchResp.predPc = addrT'(predPc);
    end

endmodule

`default_nettype wire

/* design/loadStoreUnit.sv */
`default_nettype none
`timescale 1ns/100ps

module loadStoreUnit import memPkg::*; (
    input  lsuReqT               lsuReq,
    output dataReqT              dataReq,
    input  logic                 dataDone,
    input  logic [DataWidth-1:0] dataRdata,
    output logic                 lsuDone,
    output logic [DataWidth-1:0] lsuRdata
);

    always_comb begin
        dataReq.en      = lsuReq.en;
        dataReq.addr    = lsuReq.addr;
        dataReq.wdata   = lsuReq.wdata;
        dataReq.isStore = 1'b0;
        dataReq.len     = lenT'(4);
        case (lsuReq.op)
            opLb, opLbu: begin
                dataReq.len = lenT'(1);
            end
            opLh, opLhu: begin
                dataReq.len = lenT'(2);
            end
            opLw: begin
                dataReq.len = lenT'(4);
            end
            opSb: begin
                dataReq.isStore = 1'b1;
                dataReq.len     = lenT'(1);
            end
            opSh: begin
                dataReq.isStore = 1'b1;
                dataReq.len     = lenT'(2);
            end
            opSw: begin
                dataReq.isStore = 1'b1;
                dataReq.len     = lenT'(4);
            end
            default: begin
                dataReq.isStore = 1'b0;
            end
        endcase
    end

    assign lsuDone = dataDone;

    // request stays on until done, so op still names this access
    always_comb begin
        case (lsuReq.op)
            opLb: begin
                lsuRdata = {{24{dataRdata[7]}}, dataRdata[7:0]};
            end
            opLh: begin
                lsuRdata = {{16{dataRdata[15]}}, dataRdata[15:0]};
            end
            opLbu: begin
                lsuRdata = {24'b0, dataRdata[7:0]};
            end
            opLhu: begin
                lsuRdata = {16'b0, dataRdata[15:0]};
            end
            opLw: begin
                lsuRdata = dataRdata;
            end
            default: begin
                lsuRdata = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/memSystem.sv */
`default_nettype none
`timescale 1ns/100ps

module memSystem import memPkg::*; #(
    parameter int                   AddrWidth = memPkg::AddrWidth,
    parameter logic [AddrWidth-1:0] BootPc    = '0
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rdy,
    input  logic                 ioBufferFull,
    input  logic                 fetchEn,
    input  logic                 redirect,
    input  logic [AddrWidth-1:0] redirectPc,
    input  lsuReqT               lsuReq,
    output logic                 lsuDone,
    output logic [DataWidth-1:0] lsuRdata,
    output fetchRespT            fetchResp,
    output ownerT                owner
);

    dataReqT              dataReq;
    logic                 dataDone;
    logic [DataWidth-1:0] dataRdata;

    logic                 instEn;
    logic [AddrWidth-1:0] instAddr;
    logic                 instDone;
    logic [DataWidth-1:0] instWord;

    logic [AddrWidth-1:0] ramAddr;
    logic                 ramWe;
    logic [7:0]           ramWdata;
    logic [7:0]           ramRdata;

    instFetch #(
        .AddrWidth(AddrWidth),
        .BootPc   (BootPc)
    ) fetchUnit (
        .clk       (clk),
        .rst       (rst),
        .fetchEn   (fetchEn),
        .redirect  (redirect),
        .redirectPc(redirectPc),
        .instEn    (instEn),
        .instAddr  (instAddr),
        .instDone  (instDone),
        .instWord  (instWord),
        .fetchResp (fetchResp)
    );

    loadStoreUnit lsu (
        .lsuReq   (lsuReq),
        .dataReq  (dataReq),
        .dataDone (dataDone),
        .dataRdata(dataRdata),
        .lsuDone  (lsuDone),
        .lsuRdata (lsuRdata)
    );

    memCtrl #(
        .AddrWidth(AddrWidth)
    ) ctrl (
        .clk         (clk),
        .rst         (rst),
        .rdy         (rdy),
        .ioBufferFull(ioBufferFull),
        .dataReq     (dataReq),
        .dataDone    (dataDone),
        .dataRdata   (dataRdata),
        .instEn      (instEn),
        .instAddr    (instAddr),
        .instDone    (instDone),
        .instWord    (instWord),
        .ramAddr     (ramAddr),
        .ramWe       (ramWe),
        .ramWdata    (ramWdata),
        .ramRdata    (ramRdata),
        .owner       (owner)
    );

    byteRam #(
        .AddrWidth(AddrWidth)
    ) ram (
        .clk  (clk),
        .addr (ramAddr),
        .we   (ramWe),
        .wdata(ramWdata),
        .rdata(ramRdata)
    );

endmodule

`default_nettype wire

/* verif/memSystemTb.sv */
`default_nettype none
`timescale 1ns/100ps

module memSystemTb import memPkg::*; ();

    localparam int              RamAddrWidth = 16;
    localparam logic [15:0]     BootPc       = 16'h0100;
    localparam int              ClkPeriod    = 100;
    localparam int              Iterations   = 8;
    localparam int              WaitLimit    = 60;
    localparam int              NumRequests  = Iterations * 8 + 19;

    // program with a plain op, a forward branch, a jal, nops and a backward branch
    localparam logic [15:0] ProgPc   [6] = '{16'h0100, 16'h0104, 16'h0108,
                                             16'h0110, 16'h0114, 16'h0118};
    localparam logic [31:0] ProgWord [6] = '{32'h00100093, 32'h00000463, 32'h0100006F,
                                             32'h00000013, 32'h00000013, 32'hFE101CE3};
    // fetch order as the static prediction should walk it
    localparam logic [15:0] Trace    [8] = '{16'h0100, 16'h0104, 16'h0108, 16'h0118,
                                             16'h0110, 16'h0114, 16'h0118, 16'h0110};

    logic                    clk;
    logic                    rst;
    logic                    rdy;
    logic                    ioBufferFull;
    logic                    fetchEn;
    logic                    redirect;
    logic [RamAddrWidth-1:0] redirectPc;
    lsuReqT                  lsuReq;
    logic                    lsuDone;
    logic [31:0]             lsuRdata;
    fetchRespT               fetchResp;
    ownerT                   owner;

    logic [7:0]  shadow [2**RamAddrWidth];
    int          seed          = 54;
    int          valueErrors   = 0;
    int          otherErrors   = 0;
    bit          started       = 1'b0;
    bit          checkLoad     = 1'b0;
    logic [31:0] expRdata      = '0;
    logic [31:0] expInst       = '0;
    time         lastFetchTime = 0;
    time         lastDoneTime  = 0;

    memSystem #(
        .AddrWidth(RamAddrWidth),
        .BootPc   (BootPc)
    ) UUT (
        .clk         (clk),
        .rst         (rst),
        .rdy         (rdy),
        .ioBufferFull(ioBufferFull),
        .fetchEn     (fetchEn),
        .redirect    (redirect),
        .redirectPc  (redirectPc),
        .lsuReq      (lsuReq),
        .lsuDone     (lsuDone),
        .lsuRdata    (lsuRdata),
        .fetchResp   (fetchResp),
        .owner       (owner)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(ClkPeriod * (NumRequests * 20 + 100));
        $display("watchdog expired after %0d cycles", NumRequests * 20 + 100);
        $display("test failed");
        $finish;
    end

    task automatic showMismatch(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        $display("FAILED time %0t %s: got %h expected %h", $time, name, got, exp);
        valueErrors++;
    endtask

    task automatic logFailure(input string what);
        $display("time %0t: %s", $time, what);
        otherErrors++;
    endtask

    function automatic int accessBytes(input memOpT op);
        case (op)
            opLb, opLbu, opSb: return 1;
            opLh, opLhu, opSh: return 2;
            default: return 4;
        endcase
    endfunction

    function automatic logic [31:0] shadowWord(input addrT addr);
        return {shadow[addrT'(addr + 3)], shadow[addrT'(addr + 2)],
                shadow[addrT'(addr + 1)], shadow[addr]};
    endfunction

    // RV32 load result from the shadow bytes
    function automatic logic [31:0] loadValue(input memOpT op, input addrT addr);
        logic [31:0] word;
        word = shadowWord(addr);
        case (op)
            opLb: return {{24{word[7]}}, word[7:0]};
            opLh: return {{16{word[15]}}, word[15:0]};
            opLbu: return {24'b0, word[7:0]};
            opLhu: return {16'b0, word[15:0]};
            default: return word;
        endcase
    endfunction

    loadData: assert property (@(posedge clk) disable iff (rst)
        (lsuDone && checkLoad) |-> (lsuRdata == expRdata))
        else showMismatch("lsuRdata", $sampled(lsuRdata), $sampled(expRdata));

    fetchData: assert property (@(posedge clk) disable iff (rst)
        fetchResp.valid |-> (fetchResp.inst == expInst))
        else showMismatch("fetchResp.inst", $sampled(fetchResp.inst), $sampled(expInst));

    dataOwner: assert property (@(posedge clk) disable iff (rst)
        lsuDone |-> (owner == ownerData))
        else showMismatch("owner", 32'($sampled(owner)), 32'(ownerData));

    instOwner: assert property (@(posedge clk) disable iff (rst)
        fetchResp.valid |-> (owner == ownerInst))
        else showMismatch("owner", 32'($sampled(owner)), 32'(ownerInst));

    quietStart: assert property (@(posedge clk) disable iff (rst)
        !started |-> (owner == ownerNone && !lsuDone && !fetchResp.valid))
        else logFailure("port active before any request");

    // a frozen cycle must not touch the port
    frozenPort: assert property (@(posedge clk) disable iff (rst)
        (ioBufferFull || !rdy) |-> (!UUT.ramWe && owner == ownerNone && !lsuDone
                                    && !fetchResp.valid))
        else logFailure("port activity during a stalled cycle");

    task automatic dataAccess(input memOpT op, input addrT addr, input logic [31:0] wdata,
                              input int stalls, input bit timed);
        int cycles;
        int ownCycles;
        int expCycles;
        bit isStore;
        isStore = (op == opSb || op == opSh || op == opSw);
        expCycles = accessBytes(op) + stalls + (isStore ? 0 : 1);
        @(posedge clk);
        lsuReq.en    <= 1'b1;
        lsuReq.op    <= op;
        lsuReq.addr  <= addr;
        lsuReq.wdata <= wdata;
        started      <= 1'b1;
        checkLoad    <= !isStore;
        expRdata     <= isStore ? 32'b0 : loadValue(op, addr);
        cycles = -1;
        ownCycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (owner == ownerData) begin
                ownCycles++;
            end
        end while (!lsuDone && cycles < WaitLimit);
        if (!lsuDone) begin
            logFailure($sformatf("no lsuDone for %s at %h", op.name(), addr));
        end else begin
            lastDoneTime = $time;
            if (timed) begin
                assert (cycles == expCycles)
                    else showMismatch("lsuDone latency", cycles, expCycles);
            end
            assert (ownCycles == expCycles - stalls)
                else showMismatch("data owner cycles", ownCycles, expCycles - stalls);
            if (isStore) begin
                for (int k = 0; k < accessBytes(op); k++) begin
                    shadow[addrT'(addr + k)] = wdata[8*k +: 8];
                end
            end
        end
        @(posedge clk);
        lsuReq.en <= 1'b0;
        checkLoad <= 1'b0;
    endtask

    task automatic runFetches(input int first, input int count);
        int cycles;
        int ownCycles;
        @(posedge clk);
        fetchEn <= 1'b1;
        started <= 1'b1;
        for (int i = 0; i < count; i++) begin
            expInst <= shadowWord(Trace[first + i]);
            cycles = -1;
            ownCycles = 0;
            do begin
                @(negedge clk);
                cycles++;
                if (owner == ownerInst) begin
                    ownCycles++;
                end
            end while (!fetchResp.valid && cycles < WaitLimit);
            if (!fetchResp.valid) begin
                logFailure("fetch never returned a valid word");
            end else begin
                lastFetchTime = $time;
                assert (cycles == 5) else showMismatch("fetch latency", cycles, 5);
                assert (ownCycles == 5) else showMismatch("inst owner cycles", ownCycles, 5);
                assert (fetchResp.pc == Trace[first + i])
                    else showMismatch("fetchResp.pc", 32'(fetchResp.pc), 32'(Trace[first + i]));
                assert (fetchResp.predPc == Trace[first + i + 1])
                    else showMismatch("fetchResp.predPc", 32'(fetchResp.predPc),
                                      32'(Trace[first + i + 1]));
            end
            @(posedge clk);
            if (i == count - 1) begin
                fetchEn <= 1'b0;
            end
        end
    endtask

    // stall starts in cycle 2 of the access begun on the same edge
    task automatic holdStall(input bit useRdy, input int count);
        repeat (3) @(posedge clk);
        if (useRdy) begin
            rdy <= 1'b0;
        end else begin
            ioBufferFull <= 1'b1;
        end
        repeat (count) @(posedge clk);
        rdy          <= 1'b1;
        ioBufferFull <= 1'b0;
    endtask

    initial begin
        addrT base;
        rst          = 1'b1;
        rdy          = 1'b1;
        ioBufferFull = 1'b0;
        fetchEn      = 1'b0;
        redirect     = 1'b0;
        redirectPc   = '0;
        lsuReq       = '0;
        base         = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        // no requests for a while after reset
        repeat (4) @(posedge clk);
        @(negedge clk);
        assert (fetchResp.pc == BootPc)
            else showMismatch("pc after reset", 32'(fetchResp.pc), 32'(BootPc));

        for (int it = 0; it < Iterations; it++) begin
            base = addrT'(32'h4000 + ($random(seed) & 32'h1FFC));
            dataAccess(opSw, base, $random(seed), 0, 1'b1);
            dataAccess(opSh, addrT'(base + 2 * ($random(seed) & 1)), $random(seed), 0, 1'b1);
            dataAccess(opSb, addrT'(base + ($random(seed) & 3)), $random(seed), 0, 1'b1);
            dataAccess(opLw, base, '0, 0, 1'b1);
            dataAccess(opLh, addrT'(base + 2 * ($random(seed) & 1)), '0, 0, 1'b1);
            dataAccess(opLhu, addrT'(base + 2 * ($random(seed) & 1)), '0, 0, 1'b1);
            dataAccess(opLb, addrT'(base + ($random(seed) & 3)), '0, 0, 1'b1);
            dataAccess(opLbu, addrT'(base + ($random(seed) & 3)), '0, 0, 1'b1);
        end

        for (int i = 0; i < 6; i++) begin
            dataAccess(opSw, ProgPc[i], ProgWord[i], 0, 1'b1);
        end
        runFetches(0, 7);

        @(posedge clk);
        redirect   <= 1'b1;
        redirectPc <= Trace[2];
        @(posedge clk);
        redirect <= 1'b0;
        runFetches(2, 1);

        // data request arrives mid-fetch
        fork
            runFetches(3, 1);
            begin
                repeat (3) @(posedge clk);
                dataAccess(opLw, base, '0, 0, 1'b0);
            end
        join
        assert (lastDoneTime > lastFetchTime)
            else logFailure("data access finished before the fetch in flight");

        // stalled store, then stalled loads read it back
        fork
            dataAccess(opSw, base, $random(seed), 2, 1'b1);
            holdStall(1'b1, 2);
        join
        fork
            dataAccess(opLw, base, '0, 3, 1'b1);
            holdStall(1'b0, 3);
        join
        fork
            dataAccess(opLh, base, '0, 2, 1'b1);
            holdStall(1'b1, 2);
        join

        repeat (2) @(posedge clk);
        $display("errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
        if (valueErrors + otherErrors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
design/memPkg.sv
design/byteRam.sv
design/memCtrl.sv
design/instFetch.sv
design/loadStoreUnit.sv
design/memSystem.sv
verif/memSystemTb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the memory subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module memSystemTb \
    -f sim.f \
    -o memSystemTb

output=$(./obj_dir/memSystemTb)
echo "$output"

if echo "$output" | grep -qx "test passed"; then
    exit 0
fi
exit 1
